// ==== compile.f ====
+incdir+include
hdl/gf_types_pkg.sv
hdl/ghash_ctrl_pkg.sv
hdl/gf128_mult.sv
hdl/hkey_powers.sv
hdl/parallel_ghash.sv
hdl/ghash_core.sv
hdl/ghash_top.sv
bench/tb_ghash_top.sv

// ==== Bender.yml ====
package:
  name: ghash

sources:
  # Packages first, then the design bottom up.
  - files:
      - hdl/gf_types_pkg.sv
      - hdl/ghash_ctrl_pkg.sv
      - hdl/gf128_mult.sv
      - hdl/hkey_powers.sv
      - hdl/parallel_ghash.sv
      - hdl/ghash_core.sv
      - hdl/ghash_top.sv

  # Testbench with its reference model header.
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_ghash_top.sv

// ==== include/ghash_ref.svh ====
`ifndef GHASH_REF_SVH
`define GHASH_REF_SVH

// Golden GCM multiply in Horner form.
// Walks from x^127 down to x^0.
function automatic logic [127:0] gf_mult_ref(input logic [127:0] a, input logic [127:0] b);
    logic [127:0] z;

    z = '0;
    for (int k = 0; k < 128; k++)
    begin
        // Multiply by x.
        if (z[0])
        begin
            z = (z >> 1) ^ {8'hE1, 120'd0};
        end
        else
        begin
            z = z >> 1;
        end
        // Bit k is the coefficient of x^(127-k).
        if (a[k])
        begin
            z = z ^ b;
        end
    end
    return z;
endfunction

// One serial GHASH step.
function automatic logic [127:0] ghash_fold_ref(input logic [127:0] y,
                                                input logic [127:0] x,
                                                input logic [127:0] h);
    return gf_mult_ref(y ^ x, h);
endfunction

// 32-bit xorshift generator for stimulus.
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] s;

    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

`endif

// ==== bench/tb_ghash_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ghash_top;

    import gf_types_pkg::*;
    import ghash_ctrl_pkg::*;

    `include "ghash_ref.svh"

    localparam int          P              = 4;
    localparam int          CLK_PERIOD     = 8;
    localparam int          DRIVE_DELAY    = 1;
    localparam int          MAX_TAGS       = 64;
    localparam logic [31:0] SEED           = 32'h52673181;
    // Well above the longest possible run of the sequence below.
    localparam int          TIMEOUT_CYCLES = 2000;
    // GCM test case 4, hash subkey and GHASH of A and C.
    localparam gf_block_t   TC_H           = 128'hb83b533708bf535d0aa6e52980d53b78;
    localparam gf_block_t   TC_GHASH       = 128'h698e57f70e6ecc7fd9463b7260a9ae5f;

    typedef gf_block_t [0:P-1] beat_t;

    logic        clock = 1'b0;
    logic        reset;
    logic        key_load;
    gf_block_t   hkey;
    ghash_ctrl_t ctrl;
    beat_t       blocks;
    logic        key_ready;
    gf_block_t   tag;
    logic        tag_valid;

    gf_block_t   tc_msg [7];
    gf_block_t   exp_tags [MAX_TAGS];
    int          tags_expected = 0;
    int          tags_seen = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state = SEED;
    gf_block_t   y_model;
    gf_block_t   h_model;

    ghash_top #(
        .NB_PARALLELISM (P)
    ) DUT (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_key_load  (key_load),
        .i_hkey      (hkey),
        .i_ctrl      (ctrl),
        .i_blocks    (blocks),
        .o_key_ready (key_ready),
        .o_tag       (tag),
        .o_tag_valid (tag_valid)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            fail_run($sformatf("Timeout at %0t, only %0d of %0d tags arrived.",
                               $time, tags_seen, tags_expected));
        end
    end

    always @(posedge clock)
    begin
        if (tag_valid === 1'b1)
        begin
            tags_seen <= tags_seen + 1;
        end
    end

    a_key_latency : assert property (@(posedge clock) disable iff (reset)
        key_load |=> !key_ready [*3] ##1 key_ready)
        else fail_run($sformatf("Key ready did not rise 3 cycles after key load, at %0t.",
                                $time));

    a_tag_value : assert property (@(posedge clock) disable iff (reset)
        tag_valid |-> (tags_seen < tags_expected) && (tag == exp_tags[tags_seen]))
        else fail_run($sformatf("Mismatch at %0t: tag %h, expected %h.", $time,
                                $sampled(tag), exp_tags[$sampled(tags_seen)]));

    // Tag pulse comes one cycle after the edge that takes the last beat.
    a_tag_latency : assert property (@(posedge clock) disable iff (reset)
        tag_valid |-> $past(ctrl.valid && ctrl.last, 2))
        else fail_run($sformatf("Tag valid at %0t does not follow a last beat by two edges.",
                                $time));

    function automatic logic [31:0] random_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic beat_t random_beat();
        beat_t beat;

        for (int j = 0; j < P; j++)
        begin
            beat[j] = {random_word(), random_word(), random_word(), random_word()};
        end
        return beat;
    endfunction

    // Block 0 carries data, the other slots hold junk.
    function automatic beat_t single_beat(input gf_block_t b);
        beat_t beat;

        beat    = random_beat();
        beat[0] = b;
        return beat;
    endfunction

    task automatic drive_beat(input logic first, input logic last, input logic full,
                              input beat_t data);
        @(posedge clock);
        #DRIVE_DELAY;
        ctrl   = '{valid: 1'b1, full: full, first: first, last: last};
        blocks = data;
        // Serial GHASH, one block at a time.
        if (first)
        begin
            y_model = '0;
        end
        for (int j = 0; j < (full ? P : 1); j++)
        begin
            y_model = ghash_fold_ref(y_model, data[j], h_model);
        end
        if (last)
        begin
            exp_tags[tags_expected] = y_model;
            tags_expected++;
        end
    endtask

    task automatic drive_idle();
        @(posedge clock);
        #DRIVE_DELAY;
        ctrl = '0;
    endtask

    task automatic wait_for_tags();
        while (tags_seen != tags_expected)
        begin
            @(posedge clock);
        end
    endtask

    task automatic load_key(input gf_block_t h);
        @(posedge clock);
        #DRIVE_DELAY;
        key_load = 1'b1;
        hkey     = h;
        h_model  = h;
        @(posedge clock);
        #DRIVE_DELAY;
        key_load = 1'b0;
        while (!key_ready)
        begin
            @(posedge clock);
        end
    endtask

    // Test vector, optionally with one full leading beat.
    task automatic send_vector(input logic lead_full);
        int start;

        start = 0;
        if (lead_full)
        begin
            drive_beat(1'b1, 1'b0, 1'b1, {tc_msg[0], tc_msg[1], tc_msg[2], tc_msg[3]});
            start = P;
        end
        for (int i = start; i < 7; i++)
        begin
            drive_beat(i == 0, i == 6, 1'b0, single_beat(tc_msg[i]));
        end
    endtask

    task automatic send_random_message();
        int n_items;

        n_items = 1 + int'(random_word() % 6);
        for (int i = 0; i < n_items; i++)
        begin
            drive_beat(i == 0, i == n_items - 1, (random_word() % 2) == 1, random_beat());
        end
    endtask

    initial
    begin
        reset     = 1'b1;
        key_load  = 1'b0;
        hkey      = '0;
        ctrl      = '0;
        blocks    = '0;
        y_model   = '0;
        h_model   = '0;
        // Two AAD blocks, four ciphertext blocks, then the length block.
        tc_msg[0] = 128'hfeedfacedeadbeeffeedfacedeadbeef;
        tc_msg[1] = 128'habaddad2000000000000000000000000;
        tc_msg[2] = 128'h42831ec2217774244b7221b784d0d49c;
        tc_msg[3] = 128'he3aa212f2c02a4e035c17e2329aca12e;
        tc_msg[4] = 128'h21d514b25466931c7d8f6a5aac84aa05;
        tc_msg[5] = 128'h1ba30b396a0aac973d58e09100000000;
        tc_msg[6] = 128'h00000000000000a000000000000001e0;

        repeat (4) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        a_reset_state : assert (!key_ready && !tag_valid)
            else fail_run("Key ready or tag valid is high after reset.");

        load_key(TC_H);
        send_vector(1'b0);
        a_vector_serial : assert (y_model == TC_GHASH)
            else fail_run("Reference model disagrees with the GCM test vector.");
        send_vector(1'b1);
        repeat (10) send_random_message();
        // First must clear whatever the random traffic left in Y.
        send_vector(1'b0);
        drive_idle();
        wait_for_tags();

        // New key, same message.
        load_key({random_word(), random_word(), random_word(), random_word()});
        send_vector(1'b0);
        a_new_key_differs : assert (y_model != TC_GHASH)
            else fail_run("A new key gave the same hash as the test vector key.");
        repeat (5) send_random_message();
        drive_idle();
        wait_for_tags();
        repeat (4) @(posedge clock);

        if (tags_seen == tags_expected)
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
        else
        begin
            fail_run($sformatf("Saw %0d tags but expected %0d.", tags_seen, tags_expected));
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ghash_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ghash_top
#(
    parameter int NB_PARALLELISM = 4
)
(
    input  wire                              i_clock,
    input  wire                              i_reset,
    input  wire                              i_key_load,
    input  wire gf_types_pkg::gf_block_t     i_hkey,
    input  wire ghash_ctrl_pkg::ghash_ctrl_t i_ctrl,
    input  wire gf_types_pkg::gf_block_t [0:NB_PARALLELISM-1] i_blocks,
    output logic                             o_key_ready,
    output gf_types_pkg::gf_block_t          o_tag,
    output logic                             o_tag_valid
);

    import gf_types_pkg::*;

    gf_block_t [0:NB_PARALLELISM-1] hpowers;
    gf_block_t                      data_mod;
    gf_block_t                      data_y;

    hkey_powers #(
        .NB_PARALLELISM (NB_PARALLELISM)
    ) u_hkey_powers (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_key_load  (i_key_load),
        .i_hkey      (i_hkey),
        .o_hpowers   (hpowers),
        .o_key_ready (o_key_ready)
    );

    parallel_ghash #(
        .NB_PARALLELISM (NB_PARALLELISM)
    ) u_parallel_ghash (
        .i_data_x      (i_blocks),
        .i_data_x_prev (data_y),
        .i_H           (hpowers),
        .o_data_mod    (data_mod)
    );

    // Serial path takes block 0 and H^1.
    ghash_core u_ghash_core (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_ctrl      (i_ctrl),
        .i_data_x    (i_blocks[0]),
        .i_data_mod  (data_mod),
        .i_h_key     (hpowers[0]),
        .i_key_ready (o_key_ready),
        .o_data_y    (data_y),
        .o_tag       (o_tag),
        .o_tag_valid (o_tag_valid)
    );

endmodule

`default_nettype wire

// ==== hdl/ghash_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ghash_core
(
    input  wire                            i_clock,
    input  wire                            i_reset,
    input  wire ghash_ctrl_pkg::ghash_ctrl_t i_ctrl,
    input  wire gf_types_pkg::gf_block_t   i_data_x,
    input  wire gf_types_pkg::gf_block_t   i_data_mod,
    input  wire gf_types_pkg::gf_block_t   i_h_key,
    input  wire                            i_key_ready,
    output gf_types_pkg::gf_block_t        o_data_y,
    output gf_types_pkg::gf_block_t        o_tag,
    output logic                           o_tag_valid
);

    import gf_types_pkg::*;

    gf_block_t y_q;
    gf_block_t y_prev;
    gf_block_t serial_in;
    gf_block_t serial_product;
    logic      tag_pending_q;

    // Y seen by this beat, zero at the start of a message.
    // The parallel fold uses the same value.
    assign y_prev   = i_ctrl.first ? '0 : y_q;
    assign o_data_y = y_prev;

    // Single block fold.
    assign serial_in = y_prev ^ i_data_x;

    gf128_mult u_serial_mult
    (
        .i_a       (serial_in),
        .i_b       (i_h_key),
        .o_product (serial_product)
    );

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            y_q           <= '0;
            tag_pending_q <= 1'b0;
            o_tag_valid   <= 1'b0;
        end
        else
        begin
            if (i_ctrl.valid)
            begin
                y_q <= i_ctrl.full ? i_data_mod : serial_product;
            end
            tag_pending_q <= i_ctrl.valid & i_ctrl.last;
            o_tag_valid   <= tag_pending_q;
        end
    end

    // Tag stays until the next message ends.
    always_ff @(posedge i_clock)
    begin
        if (tag_pending_q)
        begin
            o_tag <= y_q;
        end
    end

    a_beat_needs_key : assert property (@(posedge i_clock) disable iff (i_reset)
        i_ctrl.valid |-> i_key_ready)
        else $error("ghash_core: beat received before the H powers are ready");

endmodule

`default_nettype wire

// ==== hdl/parallel_ghash.sv ====
`timescale 1ns/1ps
`default_nettype none

module parallel_ghash
#(
    parameter int NB_PARALLELISM = 4
)
(
    input  wire gf_types_pkg::gf_block_t [0:NB_PARALLELISM-1] i_data_x,
    input  wire gf_types_pkg::gf_block_t                      i_data_x_prev,
    input  wire gf_types_pkg::gf_block_t [0:NB_PARALLELISM-1] i_H,
    output gf_types_pkg::gf_block_t                           o_data_mod
);

    import gf_types_pkg::*;

    gf_block_t x_adj    [NB_PARALLELISM];
    gf_block_t products [NB_PARALLELISM];

    for (genvar j = 0; j < NB_PARALLELISM; j++)
    begin : g_term
        // Previous Y enters with the oldest block only.
        if (j == 0)
        begin : g_head
            assign x_adj[j] = i_data_x[j] ^ i_data_x_prev;
        end
        else
        begin : g_tail
            assign x_adj[j] = i_data_x[j];
        end

        // Block j is scaled by H^(P-j).
        gf128_mult u_mult
        (
            .i_a       (x_adj[j]),
            .i_b       (i_H[NB_PARALLELISM-1-j]),
            .o_product (products[j])
        );
    end

    // Field addition of all terms.
    always_comb
    begin
        gf_block_t acc;

        acc = '0;
        for (int k = 0; k < NB_PARALLELISM; k++)
        begin
            acc = acc ^ products[k];
        end
        o_data_mod = acc;
    end

endmodule

`default_nettype wire

// ==== hdl/hkey_powers.sv ====
`timescale 1ns/1ps
`default_nettype none

module hkey_powers
#(
    parameter int NB_PARALLELISM = 4
)
(
    input  wire                          i_clock,
    input  wire                          i_reset,
    input  wire                          i_key_load,
    input  wire gf_types_pkg::gf_block_t i_hkey,
    output gf_types_pkg::gf_block_t [0:NB_PARALLELISM-1] o_hpowers,
    output logic                         o_key_ready
);

    import gf_types_pkg::*;
    import ghash_ctrl_pkg::*;

    localparam int IDX_W = $clog2(NB_PARALLELISM + 1);

    key_state_t       state_q;
    logic [IDX_W-1:0] idx_q;
    gf_block_t        last_power_q;
    gf_block_t        next_power;

    // One multiplier, reused once per cycle.
    gf128_mult u_power_mult
    (
        .i_a       (last_power_q),
        .i_b       (o_hpowers[0]),
        .o_product (next_power)
    );

    // Expansion FSM.
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state_q     <= KEY_IDLE;
            idx_q       <= '0;
            o_key_ready <= 1'b0;
        end
        else if (i_key_load)
        begin
            // A reload restarts the expansion from H.
            state_q     <= KEY_EXPAND;
            idx_q       <= IDX_W'(1);
            o_key_ready <= 1'b0;
        end
        else
        begin
            unique case (state_q)
                KEY_EXPAND:
                begin
                    if (int'(idx_q) >= NB_PARALLELISM - 1)
                    begin
                        state_q     <= KEY_READY;
                        o_key_ready <= 1'b1;
                    end
                    else
                    begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                default:
                begin
                    state_q <= state_q;
                end
            endcase
        end
    end

    // Power table.
    always_ff @(posedge i_clock)
    begin
        if (i_key_load)
        begin
            o_hpowers[0] <= i_hkey;
            last_power_q <= i_hkey;
        end
        else if (state_q == KEY_EXPAND && int'(idx_q) < NB_PARALLELISM)
        begin
            o_hpowers[idx_q] <= next_power;
            last_power_q     <= next_power;
        end
    end

    // Once the key is ready the power table holds until the next load.
    a_table_stable_when_ready : assert property (@(posedge i_clock) disable iff (i_reset)
        o_key_ready && !i_key_load |=> $stable(o_hpowers))
        else $error("hkey_powers: power table changed while the key was ready");

endmodule

`default_nettype wire

// ==== hdl/gf128_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

module gf128_mult
(
    input  wire gf_types_pkg::gf_block_t i_a,
    input  wire gf_types_pkg::gf_block_t i_b,
    output gf_types_pkg::gf_block_t      o_product
);

    import gf_types_pkg::*;

    // Shift and reduce over every bit of i_a.
    // Fully unrolled by synthesis into an xor tree.
    always_comb
    begin
        gf_block_t z;
        gf_block_t v;

        z = '0;
        v = i_b;
        for (int i = 0; i < GF_BLOCK_W; i++)
        begin
            // Coefficient of x^i sits at bit 127 - i.
            if (i_a[GF_BLOCK_W-1-i])
            begin
                z = z ^ v;
            end
            // Multiply v by x.
            if (v[0])
            begin
                v = (v >> 1) ^ GF_REDUCE_R;
            end
            else
            begin
                v = v >> 1;
            end
        end
        o_product = z;
    end

endmodule

`default_nettype wire

// ==== hdl/ghash_ctrl_pkg.sv ====
`default_nettype none

package ghash_ctrl_pkg;

    // Width of the key expansion state.
    localparam int KEY_STATE_W = 2;

    // Key expansion FSM states.
    typedef enum logic [KEY_STATE_W-1:0] {
        KEY_IDLE,
        KEY_EXPAND,
        KEY_READY
    } key_state_t;

    // Control that travels with one data beat.
    typedef struct packed {
        logic valid;   // Beat is present.
        logic full;    // All blocks of the beat are valid.
        logic first;   // Start a new message from Y = 0.
        logic last;    // Emit the tag after this beat.
    } ghash_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/gf_types_pkg.sv ====
`default_nettype none

package gf_types_pkg;

    // Width of one field element or data block.
    localparam int GF_BLOCK_W = 128;

    // Field element in GCM bit order.
    // Bit 127 holds the x^0 coefficient, bit 0 holds x^127.
    typedef logic [GF_BLOCK_W-1:0] gf_block_t;

    // Reduction constant for x^128 + x^7 + x^2 + x + 1, bit reflected.
    localparam gf_block_t GF_REDUCE_R = {8'hE1, 120'd0};

endpackage

`default_nettype wire
